// File: Makefile
# Verilator build and run of the scope core testbench
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_scope_dig_core
FILELIST  = sources.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: include/scope_macros.svh
/* Scope core constants
   Widths, response codes, SPI word fields, gain pot codes and trig_cfg bits */
`ifndef SCOPE_MACROS_SVH
`define SCOPE_MACROS_SVH

////////////////////
// Widths
`define SCOPE_CMD_W 24           // Host command word
`define SCOPE_SPI_W 16           // SPI transaction word
`define SCOPE_ADDR_W 9           // Channel RAM address, 512 deep
`define SCOPE_DEC_W 4            // Decimator exponent

////////////////////
// Host responses and SPI fields
`define SCOPE_RESP_ACK 8'hA5     // Positive response
`define SCOPE_RESP_ERR 8'hEE     // Failed or invalid command
`define SCOPE_TRIG_LVL_MIN 8'd46
`define SCOPE_TRIG_LVL_MAX 8'd201
`define SCOPE_SPI_DAC_PREFIX 8'h13  // Upper byte for DAC and gain pot writes

// Gain pot codes, index is the gain setting
`define SCOPE_GAIN_0 8'h02
`define SCOPE_GAIN_1 8'h05
`define SCOPE_GAIN_2 8'h09
`define SCOPE_GAIN_3 8'h14
`define SCOPE_GAIN_4 8'h28
`define SCOPE_GAIN_5 8'h46
`define SCOPE_GAIN_6 8'h6B
`define SCOPE_GAIN_7 8'hDD

// trig_cfg bit positions
`define SCOPE_TRIG_CFG_DONE 5
`define SCOPE_TRIG_CFG_EN1 0
`define SCOPE_TRIG_CFG_EN2 1

`endif

// File: sources.f
+incdir+include
verilog/scope_cmd_pkg.sv
verilog/scope_capture_pkg.sv
verilog/host_cmd_ctrl.sv
verilog/sample_timer.sv
verilog/capture_ctrl.sv
verilog/scope_dig_core.sv
test/tb_scope_dig_core.sv

// File: test/tb_scope_dig_core.sv
/* Scope core testbench
   UART and SPI models drive host commands, capture timing is watched on the RAM strobes */
`timescale 1ns/1ps
`include "scope_macros.svh"

module tb_scope_dig_core;

  logic                      clk, rst_n, trig1, trig2;
  logic                      cmd_rdy, resp_sent, spi_done;
  logic [`SCOPE_CMD_W-1:0]   cmd;
  logic [7:0]                eep_data, resp_data;
  logic                      adc_clk, rclk, wrt_spi, en, we, clr_cmd_rdy, send_resp;
  logic [`SCOPE_SPI_W-1:0]   spi_data;
  logic [`SCOPE_ADDR_W-1:0]  addr;
  scope_cmd_pkg::slave_sel_t ss;

  int         errors, timeouts;
  logic [31:0] rng;              // SPI model random state
  logic [7:0]  gain_tab [8];     // Gain pot codes by setting
  scope_cmd_pkg::slave_sel_t ch_ss [3];  // Gain pot select by channel

  scope_dig_core scope_dig_core_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  ////////////////////
  // SPI model, random back-pressure before spi_done
  initial begin : spi_model
    int delay;
    rng      = 32'd94873;
    spi_done = 1'b0;
    eep_data = 8'h00;
    forever begin
      @(posedge clk);
      if (wrt_spi) begin
        rng   = xorshift(rng);
        delay = 1 + int'(rng[2:0]);
        repeat (delay) @(posedge clk);
        eep_data <= rng[15:8];  // EEPROM byte for a read
        spi_done <= 1'b1;
        @(posedge clk);
        spi_done <= 1'b0;
      end
    end
  end

  task automatic expect_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("MISMATCH %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  ////////////////////
  // One host command through the UART model, with pulse counts
  task automatic run_cmd(input logic [`SCOPE_CMD_W-1:0] c, input bit is_spi,
                         input logic [2:0] exp_ss, input logic [`SCOPE_SPI_W-1:0] exp_spi,
                         input logic [7:0] exp_resp);
    int cyc, sent_at, done_at, n_resp, n_spi, n_clr;
    logic [7:0] got_resp, want;
    logic [`SCOPE_SPI_W-1:0] got_spi;
    logic [2:0] got_ss;
    sent_at  = -100;
    done_at  = -1;
    n_resp   = 0;
    n_spi    = 0;
    n_clr    = 0;
    got_resp = '0;
    got_spi  = '0;
    got_ss   = '0;
    @(posedge clk);
    cmd     <= c;
    cmd_rdy <= 1'b1;
    // Runs a few cycles past clr_cmd_rdy to catch stray pulses
    for (cyc = 0; cyc < 300 && (done_at < 0 || cyc < done_at + 4); cyc++) begin
      @(posedge clk);
      resp_sent <= (cyc == sent_at + 3);  // UART busy a few cycles per byte
      if (send_resp) begin
        n_resp++;
        got_resp = resp_data;
        sent_at  = cyc;
      end
      if (wrt_spi) begin
        n_spi++;
        got_spi = spi_data;
        got_ss  = ss;
      end
      if (clr_cmd_rdy) begin
        n_clr++;
        cmd_rdy <= 1'b0;
        done_at = cyc;
      end
    end
    if (done_at < 0) begin
      timeouts++;
      $display("Timeout at %0t, command 0x%h never got clr_cmd_rdy", $time, c);
    end
    want = (c[`SCOPE_CMD_W-1 -: 8] == scope_cmd_pkg::EEP_RD) ? eep_data : exp_resp;
    expect_val("send_resp count", n_resp, 1);
    expect_val("clr_cmd_rdy count", n_clr, 1);
    expect_val("wrt_spi count", n_spi, is_spi);
    expect_val("resp_data", got_resp, want);
    if (is_spi) begin
      expect_val("ss", got_ss, exp_ss);
      expect_val("spi_data", got_spi, exp_spi);
    end
  endtask

  // Counts RAM writes, checks addr steps and optional spacing
  task automatic watch_writes(input int n, input int spacing, input int limit, output int seen);
    int cyc, last, prev;
    seen = 0;
    last = 0;
    prev = 0;
    for (cyc = 0; cyc < limit && seen < n; cyc++) begin
      @(negedge clk);
      if (we) begin
        if (seen > 0) begin
          expect_val("addr", addr, (prev + 1) % 512);
          if (spacing > 0)
            expect_val("we spacing", cyc - last, spacing);
        end
        seen++;
        last = cyc;
        prev = int'(addr);
      end
    end
  endtask

  task automatic pulse_trig1();
    @(posedge clk);
    trig1 <= 1'b1;
    @(posedge clk);
    trig1 <= 1'b0;
  endtask

  ////////////////////
  // Protocol checks
  a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |->
    !(wrt_spi || send_resp || clr_cmd_rdy || en || we || scope_dig_core_inst.capture_done))
    else begin
      errors++;
      $display("Output still active when reset was released at %0t", $time);
    end

  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    (send_resp || clr_cmd_rdy) |=> !(send_resp || clr_cmd_rdy))
    else begin
      errors++;
      $display("send_resp or clr_cmd_rdy longer than one cycle at %0t", $time);
    end

  a_spi_in_cmd: assert property (@(posedge clk) disable iff (!rst_n) wrt_spi |-> cmd_rdy)
    else begin
      errors++;
      $display("wrt_spi outside a host command at %0t", $time);
    end

  // rclk runs at half the clk rate once out of reset
  a_rclk_toggle: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rst_n) |-> (rclk != $past(rclk)))
    else begin
      errors++;
      $display("rclk did not toggle at %0t", $time);
    end

  a_adc_clk_inv: assert property (@(posedge clk) disable iff (!rst_n) adc_clk == !rclk)
    else begin
      errors++;
      $display("adc_clk is not the inverse of rclk at %0t", $time);
    end

  ////////////////////
  // Stimulus
  initial begin : main
    scope_capture_pkg::cap_state_t cap_st, cap_exp;
    int i, seen;
    logic [1:0] ch;
    errors    = 0;
    timeouts  = 0;
    rst_n     = 1'b0;
    trig1     = 1'b0;
    trig2     = 1'b0;
    cmd_rdy   = 1'b0;
    resp_sent = 1'b0;
    cmd       = '0;
    gain_tab  = '{`SCOPE_GAIN_0, `SCOPE_GAIN_1, `SCOPE_GAIN_2, `SCOPE_GAIN_3,
                  `SCOPE_GAIN_4, `SCOPE_GAIN_5, `SCOPE_GAIN_6, `SCOPE_GAIN_7};
    ch_ss     = '{scope_cmd_pkg::SS_CH1, scope_cmd_pkg::SS_CH2, scope_cmd_pkg::SS_CH3};
    cap_exp   = scope_capture_pkg::CAP_DONE;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    run_cmd({scope_cmd_pkg::TRIG_RD, 16'h0}, 0, 0, 0, 8'h00);  // Reset trig_cfg
    for (i = 0; i < 8; i++) begin  // Every gain code, channels in turn
      ch = 2'(i % 3);
      run_cmd({scope_cmd_pkg::CFG_GAIN, 3'b000, 3'(i), ch, 8'h00}, 1, ch_ss[ch],
              {`SCOPE_SPI_DAC_PREFIX, gain_tab[i]}, `SCOPE_RESP_ACK);
    end
    run_cmd({scope_cmd_pkg::TRIG_LVL, 16'd46}, 1, 0, 16'h132E, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::TRIG_LVL, 16'd201}, 1, 0, 16'h13C9, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::EEP_WRT, 16'hDABC}, 1, 3'b100, {2'b01, 14'h1ABC}, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::EEP_RD, 16'h4123}, 1, 3'b100, {2'b00, 14'h0123}, 8'h00);

    // Rejected commands
    run_cmd({8'h0A, 16'h0}, 0, 0, 0, `SCOPE_RESP_ERR);
    run_cmd({scope_cmd_pkg::TRIG_LVL, 16'd45}, 0, 0, 0, `SCOPE_RESP_ERR);
    run_cmd({scope_cmd_pkg::TRIG_LVL, 16'd202}, 0, 0, 0, `SCOPE_RESP_ERR);
    run_cmd({scope_cmd_pkg::CFG_GAIN, 3'b000, 3'd2, 2'b11, 8'h00}, 0, 0, 0, `SCOPE_RESP_ERR);

    // Written done bit is dropped, capture not done yet
    run_cmd({scope_cmd_pkg::TRIG_CFG, 8'hF2, 8'h00}, 0, 0, 0, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::TRIG_RD, 16'h0}, 0, 0, 0, 8'hD2);

    for (i = 0; i <= 4; i += 2) begin  // Decimated write spacing
      run_cmd({scope_cmd_pkg::SET_DEC, 12'h0, 4'(i)}, 0, 0, 0, `SCOPE_RESP_ACK);
      watch_writes(4, 1 << (i + 1), 400, seen);
      expect_val("writes after SET_DEC", seen, 4);
    end

    ////////////////////
    // Capture with trig1, trig_pos 20
    run_cmd({scope_cmd_pkg::SET_DEC, 16'h0}, 0, 0, 0, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::TRIG_POS, 16'd20}, 0, 0, 0, `SCOPE_RESP_ACK);
    run_cmd({scope_cmd_pkg::TRIG_CFG, 8'h01, 8'h00}, 0, 0, 0, `SCOPE_RESP_ACK);
    watch_writes(3, 0, 50, seen);
    expect_val("writes before early trig1", seen, 3);
    pulse_trig1();  // Still filling, must be ignored
    watch_writes(512, 0, 1200, seen);
    expect_val("writes after early trig1", seen, 512);
    pulse_trig1();
    watch_writes(1000, 0, 100, seen);  // Post count then silence
    expect_val("writes after late trig1", seen, 20);
    cap_st = scope_dig_core_inst.u_capture_ctrl.state;
    assert (cap_st == cap_exp) else begin
      errors++;
      $display("MISMATCH %0t capture state got %s expected %s", $time, cap_st.name(),
               cap_exp.name());
    end
    run_cmd({scope_cmd_pkg::TRIG_RD, 16'h0}, 0, 0, 0, 8'h21);
    run_cmd({scope_cmd_pkg::TRIG_CFG, 8'h01, 8'h00}, 0, 0, 0, `SCOPE_RESP_ACK);
    watch_writes(4, 2, 50, seen);
    expect_val("writes after restart", seen, 4);

    $display("Errors: %0d mismatches, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog/capture_ctrl.sv
/* Capture controller
   RAM write pointer, pre-trigger fill, trigger arming and post-trigger count */
`timescale 1ns/1ps
`include "scope_macros.svh"

module capture_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     smpl_stb,
  input  logic                     trig1,
  input  logic                     trig2,
  input  logic                     trig_en1,
  input  logic                     trig_en2,
  input  logic [`SCOPE_ADDR_W-1:0] trig_pos,
  input  logic                     clr_cap_done,
  output logic                     en,
  output logic                     we,
  output logic [`SCOPE_ADDR_W-1:0] addr,
  output logic                     capture_done
);

  localparam int unsigned DEPTH = 1 << `SCOPE_ADDR_W;  // RAM depth

  scope_capture_pkg::cap_state_t state, nxt;

  logic                     wr_q;       // Write cycle, one after smpl_stb
  logic [`SCOPE_ADDR_W-1:0] wr_ptr;     // Wraps at DEPTH
  logic [`SCOPE_ADDR_W:0]   fill_cnt;   // Writes since restart, up to DEPTH
  logic [`SCOPE_ADDR_W:0]   fill_need;  // Pre-trigger writes before arming
  logic [`SCOPE_ADDR_W-1:0] post_cnt;   // Writes since trigger
  logic                     trig_hit;

  assign fill_need = DEPTH[`SCOPE_ADDR_W:0] - {1'b0, trig_pos};
  assign trig_hit  = (trig1 && trig_en1) || (trig2 && trig_en2);

  // Same strobe for all three channel RAMs
  assign en           = wr_q;
  assign we           = wr_q;
  assign addr         = wr_ptr;
  assign capture_done = (state == scope_capture_pkg::CAP_DONE);

  ////////////////////
  // Next state
  always_comb begin
    nxt = state;
    case (state)
      scope_capture_pkg::CAP_FILL: begin
        if (fill_cnt >= fill_need)
          nxt = scope_capture_pkg::CAP_ARMED;
      end
      scope_capture_pkg::CAP_ARMED: begin
        if (trig_hit)  // Triggers only count once armed
          nxt = scope_capture_pkg::CAP_POST;
      end
      scope_capture_pkg::CAP_POST: begin
        if (post_cnt == trig_pos)
          nxt = scope_capture_pkg::CAP_DONE;
      end
      default: nxt = scope_capture_pkg::CAP_DONE;  // Hold until cleared
    endcase
    if (clr_cap_done)
      nxt = scope_capture_pkg::CAP_FILL;  // Restart from any state
  end

  ////////////////////
  // State, write strobe and counters
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state    <= scope_capture_pkg::CAP_FILL;
      wr_q     <= 1'b0;
      wr_ptr   <= '0;
      fill_cnt <= '0;
      post_cnt <= '0;
    end else begin
      state <= nxt;
      // No write once the capture freezes
      wr_q  <= smpl_stb && (nxt != scope_capture_pkg::CAP_DONE);
      if (wr_q)
        wr_ptr <= wr_ptr + 1'b1;  // Keeps running across restarts
      if (clr_cap_done)
        fill_cnt <= '0;
      else if (state == scope_capture_pkg::CAP_FILL && wr_q)
        fill_cnt <= fill_cnt + 1'b1;
      if (state != scope_capture_pkg::CAP_POST)
        post_cnt <= '0;
      else if (wr_q)
        post_cnt <= post_cnt + 1'b1;
    end
  end

  ////////////////////
  // RAM strobe checks
  a_we_with_en: assert property (@(posedge clk) disable iff (!rst_n)
    we |-> en)
    else $error("we high without en");

  a_no_wr_done: assert property (@(posedge clk) disable iff (!rst_n)
    en |-> !capture_done)
    else $error("RAM write while capture_done is set");

endmodule

// File: verilog/host_cmd_ctrl.sv
/* Host command controller
   Decodes UART commands, holds config registers and runs SPI and response handshakes */
`timescale 1ns/1ps
`include "scope_macros.svh"

module host_cmd_ctrl (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`SCOPE_CMD_W-1:0]     cmd,
  input  logic                        cmd_rdy,
  input  logic                        resp_sent,
  input  logic                        spi_done,
  input  logic [7:0]                  eep_data,
  input  logic                        capture_done,
  output logic [`SCOPE_SPI_W-1:0]     spi_data,
  output logic                        wrt_spi,
  output scope_cmd_pkg::slave_sel_t   ss,
  output logic                        clr_cmd_rdy,
  output logic [7:0]                  resp_data,
  output logic                        send_resp,
  output logic [`SCOPE_ADDR_W-1:0]    trig_pos,
  output logic [`SCOPE_DEC_W-1:0]     decimator,
  output logic                        trig_en1,
  output logic                        trig_en2,
  output logic                        clr_cap_done
);

  scope_cmd_pkg::cmd_state_t state;
  scope_cmd_pkg::opcode_t    op;          // Opcode of latched command

  logic [`SCOPE_CMD_W-1:0] cmd_q;         // Command captured on acceptance
  logic [7:0]              trig_cfg;      // Done bit is never stored here
  logic [1:0]              gain_ch;
  logic [7:0]              trig_lvl;
  logic [7:0]              gain_code;
  logic                    lvl_ok;
  logic                    take_cmd;

  ////////////////////
  // Command fields
  assign op       = scope_cmd_pkg::opcode_t'(cmd_q[`SCOPE_CMD_W-1 -: 8]);
  assign gain_ch  = cmd_q[9:8];
  assign trig_lvl = cmd_q[7:0];
  assign lvl_ok   = (trig_lvl >= `SCOPE_TRIG_LVL_MIN) && (trig_lvl <= `SCOPE_TRIG_LVL_MAX);

  // cmd_rdy is still high while clr_cmd_rdy pulses, so skip that cycle
  assign take_cmd = cmd_rdy && !clr_cmd_rdy;

  assign send_resp = (state == scope_cmd_pkg::CMD_RESP);  // One cycle per command
  assign trig_en1  = trig_cfg[`SCOPE_TRIG_CFG_EN1];
  assign trig_en2  = trig_cfg[`SCOPE_TRIG_CFG_EN2];

  // Gain pot code lookup
  always_comb begin
    case (cmd_q[12:10])
      3'd0: gain_code = `SCOPE_GAIN_0;
      3'd1: gain_code = `SCOPE_GAIN_1;
      3'd2: gain_code = `SCOPE_GAIN_2;
      3'd3: gain_code = `SCOPE_GAIN_3;
      3'd4: gain_code = `SCOPE_GAIN_4;
      3'd5: gain_code = `SCOPE_GAIN_5;
      3'd6: gain_code = `SCOPE_GAIN_6;
      default: gain_code = `SCOPE_GAIN_7;
    endcase
  end

  // Latch command as it is taken
  always_ff @(posedge clk) begin
    if (state == scope_cmd_pkg::CMD_IDLE && take_cmd)
      cmd_q <= cmd;
  end

  ////////////////////
  // Command FSM with registered outputs
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state        <= scope_cmd_pkg::CMD_IDLE;
      wrt_spi      <= 1'b0;
      clr_cmd_rdy  <= 1'b0;
      clr_cap_done <= 1'b0;
      spi_data     <= '0;
      ss           <= scope_cmd_pkg::SS_TRIG;
      resp_data    <= '0;
      trig_pos     <= '0;
      decimator    <= '0;
      trig_cfg     <= '0;
    end else begin
      wrt_spi      <= 1'b0;  // Pulses default low
      clr_cmd_rdy  <= 1'b0;
      clr_cap_done <= 1'b0;
      case (state)
        scope_cmd_pkg::CMD_IDLE: begin
          if (take_cmd)
            state <= scope_cmd_pkg::CMD_DECODE;
        end
        scope_cmd_pkg::CMD_DECODE: begin
          state     <= scope_cmd_pkg::CMD_RESP;  // Register and error commands
          resp_data <= `SCOPE_RESP_ACK;
          case (op)
            scope_cmd_pkg::CFG_GAIN: begin
              if (gain_ch == 2'b11) begin
                resp_data <= `SCOPE_RESP_ERR;  // No fourth channel
              end else begin
                ss       <= scope_cmd_pkg::slave_sel_t'({1'b0, gain_ch} + 3'd1);
                spi_data <= {`SCOPE_SPI_DAC_PREFIX, gain_code};
                wrt_spi  <= 1'b1;
                state    <= scope_cmd_pkg::CMD_SPI;
              end
            end
            scope_cmd_pkg::TRIG_LVL: begin
              if (!lvl_ok) begin
                resp_data <= `SCOPE_RESP_ERR;
              end else begin
                ss       <= scope_cmd_pkg::SS_TRIG;
                spi_data <= {`SCOPE_SPI_DAC_PREFIX, trig_lvl};
                wrt_spi  <= 1'b1;
                state    <= scope_cmd_pkg::CMD_SPI;
              end
            end
            scope_cmd_pkg::TRIG_POS: trig_pos  <= cmd_q[`SCOPE_ADDR_W-1:0];
            scope_cmd_pkg::SET_DEC:  decimator <= cmd_q[`SCOPE_DEC_W-1:0];
            scope_cmd_pkg::TRIG_CFG: begin
              trig_cfg <= cmd_q[15:8];
              trig_cfg[`SCOPE_TRIG_CFG_DONE] <= 1'b0;  // Done lives in capture_ctrl
              clr_cap_done <= ~cmd_q[8 + `SCOPE_TRIG_CFG_DONE];  // Writing 0 restarts capture
            end
            scope_cmd_pkg::TRIG_RD: begin
              resp_data <= trig_cfg;
              resp_data[`SCOPE_TRIG_CFG_DONE] <= capture_done;
            end
            scope_cmd_pkg::EEP_WRT: begin
              ss       <= scope_cmd_pkg::SS_EEP;
              spi_data <= {2'b01, cmd_q[13:0]};
              wrt_spi  <= 1'b1;
              state    <= scope_cmd_pkg::CMD_SPI;
            end
            scope_cmd_pkg::EEP_RD: begin
              ss       <= scope_cmd_pkg::SS_EEP;
              spi_data <= {2'b00, cmd_q[13:0]};
              wrt_spi  <= 1'b1;
              state    <= scope_cmd_pkg::CMD_SPI;
            end
            default: resp_data <= `SCOPE_RESP_ERR;  // Unknown opcode
          endcase
        end
        scope_cmd_pkg::CMD_SPI: begin
          if (spi_done && !wrt_spi) begin  // Hold until SPI block finishes
            state     <= scope_cmd_pkg::CMD_RESP;
            resp_data <= (op == scope_cmd_pkg::EEP_RD) ? eep_data : `SCOPE_RESP_ACK;
          end
        end
        scope_cmd_pkg::CMD_RESP: state <= scope_cmd_pkg::CMD_WAIT_SENT;
        scope_cmd_pkg::CMD_WAIT_SENT: begin
          if (resp_sent) begin
            clr_cmd_rdy <= 1'b1;  // Release the UART command
            state       <= scope_cmd_pkg::CMD_IDLE;
          end
        end
        default: state <= scope_cmd_pkg::CMD_IDLE;
      endcase
    end
  end

  ////////////////////
  // Handshake checks
  a_spi_resp_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(wrt_spi && send_resp))
    else $error("wrt_spi and send_resp high together");

  a_clr_after_sent: assert property (@(posedge clk) disable iff (!rst_n)
    clr_cmd_rdy |-> $past(resp_sent))
    else $error("clr_cmd_rdy without resp_sent the cycle before");

endmodule

// File: verilog/sample_timer.sv
/* Sample timer
   RAM and ADC clocks plus the decimated sample strobe */
`timescale 1ns/1ps
`include "scope_macros.svh"

module sample_timer (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic [`SCOPE_DEC_W-1:0]  decimator,
  output logic                     rclk,
  output logic                     adc_clk,
  output logic                     smpl_stb
);

  // Rising edge count wide enough for the largest interval
  localparam int CNT_W = (1 << `SCOPE_DEC_W) - 1;

  logic [CNT_W-1:0] rise_cnt;  // rclk rising edges since last strobe
  logic [CNT_W-1:0] last;      // Final count of an interval

  assign last    = CNT_W'((32'd1 << decimator) - 32'd1);  // 2^decimator rclk periods
  assign adc_clk = ~rclk;  // ADC samples opposite phase

  // Half rate clock
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n)
      rclk <= 1'b0;
    else
      rclk <= ~rclk;
  end

  ////////////////////
  // Strobe on rclk rise, once per interval
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      rise_cnt <= '0;
      smpl_stb <= 1'b0;
    end else begin
      smpl_stb <= 1'b0;
      if (!rclk) begin  // rclk rises on this edge
        if (rise_cnt >= last) begin  // Also catches a shrunk decimator
          rise_cnt <= '0;
          smpl_stb <= 1'b1;
        end else begin
          rise_cnt <= rise_cnt + 1'b1;
        end
      end
    end
  end

  a_stb_on_rise: assert property (@(posedge clk) disable iff (!rst_n)
    smpl_stb |-> $rose(rclk))
    else $error("smpl_stb away from an rclk rising edge");

endmodule

// File: verilog/scope_capture_pkg.sv
/* Capture control types
   States of the capture FSM */
package scope_capture_pkg;

  ////////////////////
  // Capture FSM
  typedef enum logic [1:0] {
    CAP_FILL,   // Collect pre-trigger samples
    CAP_ARMED,  // Enough history, waiting on an enabled trigger
    CAP_POST,   // Trigger seen, counting trig_pos more samples
    CAP_DONE    // Capture frozen until cleared
  } cap_state_t;

endpackage

// File: verilog/scope_cmd_pkg.sv
/* Host command types
   Opcodes, SPI slave selects and the command FSM states */
package scope_cmd_pkg;

  ////////////////////
  // Opcodes in the top byte of a host command
  typedef enum logic [7:0] {
    CFG_GAIN = 8'h02,  // Channel gain pot, gain in bits 12:10, channel in 9:8
    TRIG_LVL = 8'h03,  // Trigger DAC level in the low byte
    TRIG_POS = 8'h04,  // Samples kept after the trigger
    SET_DEC  = 8'h05,  // Decimator exponent in the low nibble
    TRIG_CFG = 8'h06,  // Write trig_cfg from the middle byte
    TRIG_RD  = 8'h07,  // Read back trig_cfg
    EEP_WRT  = 8'h08,  // Calibration EEPROM write
    EEP_RD   = 8'h09   // Calibration EEPROM read
  } opcode_t;

  // Slave select seen by the SPI block
  typedef enum logic [2:0] {
    SS_TRIG = 3'b000,  // Trigger level DAC
    SS_CH1  = 3'b001,
    SS_CH2  = 3'b010,
    SS_CH3  = 3'b011,
    SS_EEP  = 3'b100   // Calibration EEPROM
  } slave_sel_t;

  ////////////////////
  // Command FSM
  typedef enum logic [2:0] {
    CMD_IDLE,       // Wait for cmd_rdy
    CMD_DECODE,     // Decode latched command
    CMD_SPI,        // Wait for spi_done
    CMD_RESP,       // send_resp pulse
    CMD_WAIT_SENT   // Wait for resp_sent
  } cmd_state_t;

endpackage

// File: verilog/scope_dig_core.sv
/* Oscilloscope digital core
   Host command control, sample timing and capture control under one top */
`timescale 1ns/1ps
`include "scope_macros.svh"

module scope_dig_core (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       trig1,      // Trigger events from the AFE
  input  logic                       trig2,
  input  logic [`SCOPE_CMD_W-1:0]    cmd,        // From UART
  input  logic                       cmd_rdy,
  input  logic                       resp_sent,
  input  logic                       spi_done,
  input  logic [7:0]                 eep_data,   // EEPROM read byte from SPI
  output logic                       adc_clk,
  output logic                       rclk,
  output logic [`SCOPE_SPI_W-1:0]    spi_data,
  output logic                       wrt_spi,
  output scope_cmd_pkg::slave_sel_t  ss,
  output logic                       en,         // Shared by the channel RAMs
  output logic                       we,
  output logic [`SCOPE_ADDR_W-1:0]   addr,
  output logic                       clr_cmd_rdy,
  output logic [7:0]                 resp_data,
  output logic                       send_resp
);

  ////////////////////
  // Interconnect
  logic [`SCOPE_DEC_W-1:0]  decimator;
  logic [`SCOPE_ADDR_W-1:0] trig_pos;
  logic                     trig_en1;
  logic                     trig_en2;
  logic                     clr_cap_done;  // One cycle restart request
  logic                     capture_done;
  logic                     smpl_stb;      // One cycle per decimated sample

  host_cmd_ctrl u_host_cmd_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd          (cmd),
    .cmd_rdy      (cmd_rdy),
    .resp_sent    (resp_sent),
    .spi_done     (spi_done),
    .eep_data     (eep_data),
    .capture_done (capture_done),
    .spi_data     (spi_data),
    .wrt_spi      (wrt_spi),
    .ss           (ss),
    .clr_cmd_rdy  (clr_cmd_rdy),
    .resp_data    (resp_data),
    .send_resp    (send_resp),
    .trig_pos     (trig_pos),
    .decimator    (decimator),
    .trig_en1     (trig_en1),
    .trig_en2     (trig_en2),
    .clr_cap_done (clr_cap_done)
  );

  sample_timer u_sample_timer (
    .clk       (clk),
    .rst_n     (rst_n),
    .decimator (decimator),
    .rclk      (rclk),
    .adc_clk   (adc_clk),
    .smpl_stb  (smpl_stb)
  );

  capture_ctrl u_capture_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .smpl_stb     (smpl_stb),
    .trig1        (trig1),
    .trig2        (trig2),
    .trig_en1     (trig_en1),
    .trig_en2     (trig_en2),
    .trig_pos     (trig_pos),
    .clr_cap_done (clr_cap_done),
    .en           (en),
    .we           (we),
    .addr         (addr),
    .capture_done (capture_done)
  );

endmodule
